/* files.f */
+incdir+include
rtl/sleep_tracker_pkg.sv
rtl/uart_rx_sequencer.sv
rtl/packet_engine.sv
rtl/register_map.sv
rtl/nn_loader.sv
rtl/record_fifo.sv
rtl/sleep_tracker_top.sv
tests/sleep_tracker_assert.sv
tests/sleep_tracker_tb.sv

/* include/sleep_tracker_params.svh */
// Sizes and bit positions shared by the sleep tracker control unit
// The register map and FIFO depth are assumed to be powers of two
`ifndef SLEEP_TRACKER_PARAMS_SVH
`define SLEEP_TRACKER_PARAMS_SVH

// ====================================================================
// Register map
// ====================================================================
`define REG_MAP_BYTES 256
`define REG_ADDR_W 8
`define CMD_REG_ADDR 128
`define START_BIT 7

// ====================================================================
// Host packet header
// ====================================================================
`define HDR_WRITE_BIT 7
`define HDR_FIFO_BIT 6
`define HDR_COUNT_W 4
`define PKT_COUNT_W 16

// Network inputs, count sits at bits 23 to 16 of each word
`define NN_INPUTS 4
`define NN_ADDR_W 2
`define NN_DATA_W 32
`define NN_COUNT_LSB 16

`define RECORD_FIFO_DEPTH 8

`endif

/* rtl/nn_loader.sv */
// Loads each activity count into every network input, then starts inference
// Counts that arrive while busy are ignored; one result per start is expected
`timescale 1ns/1ps
`include "sleep_tracker_params.svh"

module nn_loader (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          i_start_enable,
    input  logic                          i_count_valid,
    input  logic [7:0]                    i_count,
    input  logic                          i_nn_done,
    input  logic [7:0]                    i_nn_class,
    output logic [`NN_ADDR_W-1:0]         o_nn_addr,
    output logic [`NN_DATA_W-1:0]         o_nn_data,
    output logic                          o_nn_we,
    output logic                          o_nn_start,
    output logic                          o_push,
    output sleep_tracker_pkg::fifo_word_u o_push_word
);
    typedef enum logic [1:0] {
        NN_IDLE,
        NN_STORE,
        NN_START,
        NN_WAIT
    } state_t;

    state_t state;
    logic [`NN_ADDR_W-1:0] idx_q;
    logic [7:0] count_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= NN_IDLE;
            idx_q <= '0;
        end else begin
            case (state)
                NN_IDLE: begin
                    if (i_start_enable && i_count_valid) state <= NN_STORE;
                end
                NN_STORE: begin
                    if (idx_q == `NN_ADDR_W'(`NN_INPUTS - 1)) state <= NN_START;
                end
                NN_START: state <= NN_WAIT;
                NN_WAIT: begin
                    if (i_nn_done) state <= NN_IDLE;
                end
                default: state <= NN_IDLE;
            endcase
            idx_q <= (state == NN_STORE) ? idx_q + 1'b1 : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == NN_IDLE && i_count_valid) begin
            count_q <= i_count;
        end
    end

    assign o_nn_we    = (state == NN_STORE);
    assign o_nn_addr  = idx_q;
    assign o_nn_data  = o_nn_we ? (`NN_DATA_W'(count_q) << `NN_COUNT_LSB) : '0;
    assign o_nn_start = (state == NN_START);

    // Result record goes straight to the FIFO
    assign o_push = (state == NN_WAIT) && i_nn_done;
    always_comb begin
        o_push_word.rec.nn_class = i_nn_class;
        o_push_word.rec.count    = count_q;
    end

endmodule

/* rtl/packet_engine.sv */
// Host packet decoder: header, address low, address high, then payload or transmit
// Relies on the received byte holding until the next fetch; zero-length packets end at once
`timescale 1ns/1ps
`include "sleep_tracker_params.svh"

module packet_engine (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          i_byte_valid,
    input  logic [7:0]                    i_rx_byte,
    input  logic                          i_tx_ready,
    output logic                          o_write_strobe,
    output logic [7:0]                    o_write_data,
    output logic                          o_reg_we,
    output logic [`REG_ADDR_W-1:0]        o_reg_addr,
    output logic [7:0]                    o_reg_din,
    input  logic [7:0]                    i_reg_dout,
    input  logic                          i_fifo_empty,
    input  sleep_tracker_pkg::fifo_word_u i_fifo_word,
    output logic                          o_fifo_pop
);
    typedef enum logic [2:0] {
        ST_HEADER,
        ST_ADDR_LO,
        ST_ADDR_HI,
        ST_PAYLOAD,
        ST_WRITE,
        ST_TX_WAIT,
        ST_TX_LOAD,
        ST_TX_SEND
    } state_t;

    state_t state, next_state;
    logic write_q, fifo_q;
    logic [`PKT_COUNT_W-1:0] count_q, base_q, index_q, total_count;
    logic last_byte;
    sleep_tracker_pkg::fifo_word_u tx_word_q;

    // Count as it stands once the high address byte arrives
    assign total_count = fifo_q ? {i_rx_byte, count_q[7:0]} : count_q;
    assign last_byte   = (index_q == count_q - 1'b1);

    // ================================================================
    // Next state
    // ================================================================
    always_comb begin
        next_state = state;
        case (state)
            ST_HEADER: begin
                if (i_byte_valid) next_state = ST_ADDR_LO;
            end
            ST_ADDR_LO: begin
                if (i_byte_valid) next_state = ST_ADDR_HI;
            end
            ST_ADDR_HI: begin
                if (i_byte_valid) begin
                    if (total_count == '0) begin
                        next_state = ST_HEADER;
                    end else begin
                        next_state = write_q ? ST_PAYLOAD : ST_TX_WAIT;
                    end
                end
            end
            ST_PAYLOAD: begin
                if (i_byte_valid) next_state = ST_WRITE;
            end
            ST_WRITE:   next_state = last_byte ? ST_HEADER : ST_PAYLOAD;
            ST_TX_WAIT: begin
                if (i_tx_ready) begin
                    // Empty FIFO only ends the packet at a record boundary
                    if (fifo_q && !index_q[0] && i_fifo_empty) begin
                        next_state = ST_HEADER;
                    end else begin
                        next_state = ST_TX_LOAD;
                    end
                end
            end
            ST_TX_LOAD: next_state = ST_TX_SEND;
            ST_TX_SEND: next_state = last_byte ? ST_HEADER : ST_TX_WAIT;
            default:    next_state = ST_HEADER;
        endcase
    end

    // ================================================================
    // Packet fields and byte index
    // ================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= ST_HEADER;
            write_q <= 1'b0;
            fifo_q  <= 1'b0;
            count_q <= '0;
            base_q  <= '0;
            index_q <= '0;
        end else begin
            state <= next_state;
            if (state == ST_HEADER && i_byte_valid) begin
                write_q <= i_rx_byte[`HDR_WRITE_BIT];
                fifo_q  <= i_rx_byte[`HDR_FIFO_BIT] & ~i_rx_byte[`HDR_WRITE_BIT];
                count_q <= `PKT_COUNT_W'(i_rx_byte[`HDR_COUNT_W-1:0]);
                base_q  <= '0;
                index_q <= '0;
            end
            // FIFO reads carry the byte count in the address bytes
            if (state == ST_ADDR_LO && i_byte_valid) begin
                if (fifo_q) count_q[7:0] <= i_rx_byte;
                else base_q[7:0] <= i_rx_byte;
            end
            if (state == ST_ADDR_HI && i_byte_valid) begin
                if (fifo_q) count_q[15:8] <= i_rx_byte;
                else base_q[15:8] <= i_rx_byte;
            end
            if (state == ST_WRITE || state == ST_TX_SEND) begin
                index_q <= index_q + 1'b1;
            end
        end
    end

    // Head record is held here while the FIFO advances
    always_ff @(posedge clk) begin
        if (o_fifo_pop) begin
            tx_word_q <= i_fifo_word;
        end
    end

    assign o_reg_we   = (state == ST_WRITE);
    assign o_reg_addr = base_q[`REG_ADDR_W-1:0] + index_q[`REG_ADDR_W-1:0];
    assign o_reg_din  = i_rx_byte;
    assign o_fifo_pop = (state == ST_TX_LOAD) && fifo_q && !index_q[0];

    // Count byte first, class byte second
    assign o_write_strobe = (state == ST_TX_SEND);
    assign o_write_data   = fifo_q ? (index_q[0] ? tx_word_q.bytes.hi : tx_word_q.bytes.lo)
                                   : i_reg_dout;

endmodule

/* rtl/record_fifo.sv */
// Circular buffer of result records; pushes into a full FIFO are dropped
// Pops on an empty FIFO are ignored, o_word shows the head entry
`timescale 1ns/1ps
`include "sleep_tracker_params.svh"

module record_fifo (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          i_push,
    input  sleep_tracker_pkg::fifo_word_u i_push_word,
    input  logic                          i_pop,
    output sleep_tracker_pkg::fifo_word_u o_word,
    output logic                          o_empty
);
    localparam int PTR_W = $clog2(`RECORD_FIFO_DEPTH);

    sleep_tracker_pkg::fifo_word_u mem [`RECORD_FIFO_DEPTH];

    // Extra pointer bit tells full from empty
    logic [PTR_W:0] wr_ptr, rd_ptr;
    logic full, do_push, do_pop;

    assign o_empty = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                     (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
    assign do_push = i_push && !full;
    assign do_pop  = i_pop && !o_empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr[PTR_W-1:0]] <= i_push_word;
        end
    end

    assign o_word = mem[rd_ptr[PTR_W-1:0]];

endmodule

/* rtl/register_map.sv */
// Host register map with one cycle read latency, RAM contents not reset
// Only the start bit of the command register is decoded here
`timescale 1ns/1ps
`include "sleep_tracker_params.svh"

module register_map (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   i_we,
    input  logic [`REG_ADDR_W-1:0] i_addr,
    input  logic [7:0]             i_din,
    output logic [7:0]             o_dout,
    output logic                   o_start_enable
);
    logic [7:0] mem [`REG_MAP_BYTES];

    // Read returns the old contents on a write to the same address
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_addr] <= i_din;
        end
        o_dout <= mem[i_addr];
    end

    // Command register enable
    always_ff @(posedge clk) begin
        if (reset) begin
            o_start_enable <= 1'b0;
        end else if (i_we && i_addr == `REG_ADDR_W'(`CMD_REG_ADDR)) begin
            o_start_enable <= i_din[`START_BIT];
        end
    end

endmodule

/* rtl/sleep_tracker_pkg.sv */
// Record word for the result FIFO, seen as a record or as two bytes
// Both views cover the same 16 bits, class and hi share the upper byte
package sleep_tracker_pkg;

    // Inference result as stored
    typedef struct packed {
        logic [7:0] nn_class;
        logic [7:0] count;
    } record_t;

    // Same word split for byte-wide UART transmit
    typedef struct packed {
        logic [7:0] hi;
        logic [7:0] lo;
    } byte_pair_t;

    typedef union packed {
        record_t    rec;
        byte_pair_t bytes;
    } fifo_word_u;

endpackage

/* rtl/sleep_tracker_top.sv */
// Sleep tracker control unit: UART host packets, register map, inference loader
// Host UART and network block sit outside; all handshakes are single-cycle strobes
`timescale 1ns/1ps
`include "sleep_tracker_params.svh"

module sleep_tracker_top (
    input  logic                  clk,
    input  logic                  reset,
    // UART
    input  logic                  i_rx_ready,
    input  logic                  i_read_valid,
    input  logic [7:0]            i_read_data,
    output logic                  o_read_strobe,
    input  logic                  i_tx_ready,
    output logic                  o_write_strobe,
    output logic [7:0]            o_write_data,
    // Network
    output logic [`NN_ADDR_W-1:0] o_nn_addr,
    output logic [`NN_DATA_W-1:0] o_nn_data,
    output logic                  o_nn_we,
    output logic                  o_nn_start,
    input  logic                  i_nn_done,
    input  logic [7:0]            i_nn_class,
    // Activity count
    input  logic                  i_count_valid,
    input  logic [7:0]            i_count
);
    logic byte_valid;
    logic [7:0] rx_byte;
    logic reg_we;
    logic [`REG_ADDR_W-1:0] reg_addr;
    logic [7:0] reg_din, reg_dout;
    logic start_enable;
    logic fifo_empty, fifo_pop, push;
    sleep_tracker_pkg::fifo_word_u fifo_word, push_word;

    uart_rx_sequencer rx_seq_i (
        .clk           (clk),
        .reset         (reset),
        .i_rx_ready    (i_rx_ready),
        .i_read_valid  (i_read_valid),
        .i_read_data   (i_read_data),
        .o_read_strobe (o_read_strobe),
        .o_byte_valid  (byte_valid),
        .o_rx_byte     (rx_byte)
    );

    packet_engine packet_i (
        .clk            (clk),
        .reset          (reset),
        .i_byte_valid   (byte_valid),
        .i_rx_byte      (rx_byte),
        .i_tx_ready     (i_tx_ready),
        .o_write_strobe (o_write_strobe),
        .o_write_data   (o_write_data),
        .o_reg_we       (reg_we),
        .o_reg_addr     (reg_addr),
        .o_reg_din      (reg_din),
        .i_reg_dout     (reg_dout),
        .i_fifo_empty   (fifo_empty),
        .i_fifo_word    (fifo_word),
        .o_fifo_pop     (fifo_pop)
    );

    register_map regs_i (
        .clk            (clk),
        .reset          (reset),
        .i_we           (reg_we),
        .i_addr         (reg_addr),
        .i_din          (reg_din),
        .o_dout         (reg_dout),
        .o_start_enable (start_enable)
    );

    nn_loader loader_i (
        .clk            (clk),
        .reset          (reset),
        .i_start_enable (start_enable),
        .i_count_valid  (i_count_valid),
        .i_count        (i_count),
        .i_nn_done      (i_nn_done),
        .i_nn_class     (i_nn_class),
        .o_nn_addr      (o_nn_addr),
        .o_nn_data      (o_nn_data),
        .o_nn_we        (o_nn_we),
        .o_nn_start     (o_nn_start),
        .o_push         (push),
        .o_push_word    (push_word)
    );

    record_fifo fifo_i (
        .clk         (clk),
        .reset       (reset),
        .i_push      (push),
        .i_push_word (push_word),
        .i_pop       (fifo_pop),
        .o_word      (fifo_word),
        .o_empty     (fifo_empty)
    );

endmodule

/* rtl/uart_rx_sequencer.sv */
// Fetches one byte per UART ready indication; read latency may vary
// The captured byte stays stable until the next fetch completes
`timescale 1ns/1ps

module uart_rx_sequencer (
    input  logic       clk,
    input  logic       reset,
    input  logic       i_rx_ready,
    input  logic       i_read_valid,
    input  logic [7:0] i_read_data,
    output logic       o_read_strobe,
    output logic       o_byte_valid,
    output logic [7:0] o_rx_byte
);
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_STROBE,
        RX_WAIT,
        RX_DELIVER
    } state_t;

    state_t state;
    logic [7:0] byte_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= RX_IDLE;
        end else begin
            case (state)
                RX_IDLE:    state <= i_rx_ready ? RX_STROBE : RX_IDLE;
                RX_STROBE:  state <= RX_WAIT;
                RX_WAIT:    state <= i_read_valid ? RX_DELIVER : RX_WAIT;
                RX_DELIVER: state <= RX_IDLE;
                default:    state <= RX_IDLE;
            endcase
        end
    end

    // Byte capture
    always_ff @(posedge clk) begin
        if (state == RX_WAIT && i_read_valid) begin
            byte_q <= i_read_data;
        end
    end

    assign o_read_strobe = (state == RX_STROBE);
    assign o_byte_valid  = (state == RX_DELIVER);
    assign o_rx_byte     = byte_q;

endmodule

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it; the exit status gives pass or fail
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module sleep_tracker_tb \
    --Mdir obj_dir \
    -f files.f
./obj_dir/Vsleep_tracker_tb

/* tests/sleep_tracker_assert.sv */
// Protocol assertions bound to the top level, sampled on the rising clock edge
// Strobe timing assumes the fixed latencies of the packet engine and the loader
`timescale 1ns/1ps
`include "sleep_tracker_params.svh"

module sleep_tracker_assert (
    input logic                  clk,
    input logic                  reset,
    input logic                  i_tx_ready,
    input logic                  o_read_strobe,
    input logic                  o_write_strobe,
    input logic                  o_nn_we,
    input logic [`NN_ADDR_W-1:0] o_nn_addr,
    input logic                  o_nn_start
);
    localparam logic [`NN_ADDR_W-1:0] LAST_ADDR = `NN_ADDR_W'(`NN_INPUTS - 1);

    // ================================================================
    // UART strobes
    // ================================================================
    reset_quiet: assert property (@(posedge clk)
        reset |=> !o_read_strobe && !o_write_strobe && !o_nn_we && !o_nn_start)
        else $error("a strobe was active right after reset");

    // Transmit only after ready was seen in the wait step
    tx_after_ready: assert property (@(posedge clk) disable iff (reset)
        o_write_strobe |-> $past(i_tx_ready, 2))
        else $error("o_write_strobe without i_tx_ready two cycles before");

    // ================================================================
    // Network loading
    // ================================================================
    writes_in_order: assert property (@(posedge clk) disable iff (reset)
        o_nn_we && o_nn_addr != '0 |-> $past(o_nn_we) && $past(o_nn_addr) == o_nn_addr - 1'b1)
        else $error("network input writes out of order");

    start_after_last: assert property (@(posedge clk) disable iff (reset)
        o_nn_we && o_nn_addr == LAST_ADDR |=> o_nn_start)
        else $error("no o_nn_start after the last input write");

    start_only_after_last: assert property (@(posedge clk) disable iff (reset)
        o_nn_start |-> $past(o_nn_we) && $past(o_nn_addr) == LAST_ADDR)
        else $error("o_nn_start without a complete input load");

endmodule

/* tests/sleep_tracker_tb.sv */
// Testbench with UART host and network models; stimulus randomness from a fixed LFSR
// Register reads must not overlap the next packet, so each packet is run to completion
`timescale 1ns/1ps
`include "sleep_tracker_params.svh"

module sleep_tracker_tb;
    localparam int CLK_PERIOD = 40;
    localparam logic [7:0] NN_CLASS = 8'h5a;
    // Rough length: UART bytes in, bytes out, inference runs, settle time
    localparam int EST_CYCLES = 80 * 10 + 48 * 8 + 4 * 20 + 200;

    logic clk = 1'b0;
    logic reset;
    logic i_rx_ready, i_read_valid, i_tx_ready, i_nn_done, i_count_valid;
    logic [7:0] i_read_data, i_nn_class, i_count;
    logic o_read_strobe, o_write_strobe, o_nn_we, o_nn_start;
    logic [7:0] o_write_data;
    logic [`NN_ADDR_W-1:0] o_nn_addr;
    logic [`NN_DATA_W-1:0] o_nn_data;

    logic [31:0] lfsr = 32'ha321_cd97;
    logic [7:0] rx_q[$], tx_q[$], exp_q[$], rec_q[$];
    logic [7:0] last_count = 8'h00;
    logic rx_pending = 1'b0, tx_random = 1'b0, nn_busy = 1'b0;
    int rx_delay, nn_delay;
    int load_idx = 0, load_cycles = 0, starts = 0, results = 0;

    sleep_tracker_top dut_i (.*);

    bind sleep_tracker_top sleep_tracker_assert assert_i (
        .clk            (clk),
        .reset          (reset),
        .i_tx_ready     (i_tx_ready),
        .o_read_strobe  (o_read_strobe),
        .o_write_strobe (o_write_strobe),
        .o_nn_we        (o_nn_we),
        .o_nn_addr      (o_nn_addr),
        .o_nn_start     (o_nn_start)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [7:0] take_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[6:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else stop_with_failure($sformatf("error at %0t ns: %s expected 0x%0h, actual 0x%0h",
                                         $time, name, expected, actual));
    endtask

    // ================================================================
    // UART host and network models
    // ================================================================
    // DUT outputs are sampled mid-cycle
    always @(negedge clk) begin
        if (o_read_strobe) begin
            if (rx_q.size() == 0) stop_with_failure("read strobe with no host byte queued");
            rx_pending = 1'b1;
            rx_delay = int'(take_bits(2));
        end
        if (o_write_strobe) tx_q.push_back(o_write_data);
    end

    always @(posedge clk) begin
        i_read_valid <= 1'b0;
        if (rx_pending && rx_delay == 0) begin
            i_read_data <= rx_q.pop_front();
            i_read_valid <= 1'b1;
            rx_pending = 1'b0;
        end else if (rx_pending) begin
            rx_delay--;
        end
        i_rx_ready <= (rx_q.size() != 0);
        i_tx_ready <= tx_random ? (take_bits(1) != 0) : 1'b1;
    end

    // Count expected at bits 23 to 16, zeros elsewhere
    always @(negedge clk) begin
        if (o_nn_we) begin
            check_value("o_nn_addr", load_idx, 32'(o_nn_addr));
            check_value("o_nn_data", {8'h00, last_count, 16'h0000}, o_nn_data);
            load_idx++;
            load_cycles++;
        end
        if (o_nn_start) begin
            check_value("input writes before o_nn_start", `NN_INPUTS, load_idx);
            load_idx = 0;
            starts++;
            nn_busy = 1'b1;
            nn_delay = 3;
        end
    end

    always @(posedge clk) begin
        i_nn_done <= 1'b0;
        if (nn_busy && nn_delay == 0) begin
            i_nn_done <= 1'b1;
            nn_busy = 1'b0;
            results++;
        end else if (nn_busy) begin
            nn_delay--;
        end
    end

    // ================================================================
    // Packet and count tasks
    // ================================================================
    task automatic queue_bytes(input logic [7:0] header, input logic [15:0] word);
        rx_q.push_back(header);
        rx_q.push_back(word[7:0]);
        rx_q.push_back(word[15:8]);
    endtask

    // Last byte takes effect three cycles after its read data
    task automatic drain_host();
        while (rx_q.size() != 0 || rx_pending) @(posedge clk);
        repeat (4) @(posedge clk);
    endtask

    task automatic write_random(input logic [15:0] base, input int n);
        logic [7:0] b;
        exp_q.delete();
        queue_bytes((8'd1 << `HDR_WRITE_BIT) | 8'(n), base);
        for (int k = 0; k < n; k++) begin
            b = take_bits(8);
            rx_q.push_back(b);
            exp_q.push_back(b);
        end
        drain_host();
    endtask

    task automatic write_cmd(input logic [7:0] value);
        queue_bytes((8'd1 << `HDR_WRITE_BIT) | 8'd1, 16'(`CMD_REG_ADDR));
        rx_q.push_back(value);
        drain_host();
    endtask

    task automatic read_and_compare(input logic [7:0] header, input logic [15:0] word);
        tx_q.delete();
        queue_bytes(header, word);
        drain_host();
        while (tx_q.size() < exp_q.size()) @(posedge clk);
        repeat (8) @(posedge clk);
        check_value("returned byte count", exp_q.size(), tx_q.size());
        foreach (exp_q[i]) check_value($sformatf("o_write_data[%0d]", i), exp_q[i], tx_q[i]);
    endtask

    task automatic pulse_count(input logic [7:0] count, input bit enabled);
        int loads_before, starts_before, results_before;
        loads_before = load_cycles;
        starts_before = starts;
        results_before = results;
        last_count = count;
        i_count <= count;
        i_count_valid <= 1'b1;
        @(posedge clk);
        i_count_valid <= 1'b0;
        if (enabled) begin
            while (results == results_before) @(posedge clk);
            repeat (2) @(posedge clk);
            check_value("input write cycles", loads_before + `NN_INPUTS, load_cycles);
            rec_q.push_back(count);
            rec_q.push_back(NN_CLASS);
        end else begin
            repeat (16) @(posedge clk);
            check_value("input write cycles", loads_before, load_cycles);
            check_value("o_nn_start pulses", starts_before, starts);
        end
    endtask

    // ================================================================
    // Test sequence
    // ================================================================
    initial begin
        reset = 1'b1;
        i_rx_ready = 1'b0;
        i_read_valid = 1'b0;
        i_read_data = 8'h00;
        i_tx_ready = 1'b1;
        i_nn_done = 1'b0;
        i_nn_class = NN_CLASS;
        i_count_valid = 1'b0;
        i_count = 8'h00;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_value("o_read_strobe", 0, 32'(o_read_strobe));
            check_value("o_write_strobe", 0, 32'(o_write_strobe));
            check_value("o_nn_we", 0, 32'(o_nn_we));
            check_value("o_nn_start", 0, 32'(o_nn_start));
        end
        @(posedge clk);
        // Loader off and FIFO empty after reset
        pulse_count(8'h33, 1'b0);
        exp_q.delete();
        read_and_compare(8'h40, 16'd4);
        // Write then read back; the high address byte is outside the 8-bit map
        write_random(16'h0010, 12);
        read_and_compare(8'h0c, 16'h0110);
        tx_random = 1'b1;
        read_and_compare(8'h0c, 16'h0010);
        write_random(16'h00fa, 10);
        read_and_compare(8'h0a, 16'h00fa);
        // Inference records come back as count then class
        write_cmd(8'h80);
        repeat (3) pulse_count(take_bits(8), 1'b1);
        exp_q = rec_q;
        read_and_compare(8'h40, 16'd6);
        write_cmd(8'h00);
        pulse_count(take_bits(8), 1'b0);
        $display("TESTBENCH PASSED");
        $finish;
    end

    initial begin
        #(4 * EST_CYCLES * CLK_PERIOD);
        stop_with_failure("timeout: the tests did not finish in the expected time");
    end

endmodule
